//--- hdl/ifu_geom_pkg.sv
// fetch geometry package with widths, pc and fetch address types, parcel mask helper
`default_nettype none

package ifu_geom_pkg;

   localparam int PC_W              = 31;                        // halfword pc is bits 31:1
   localparam int FETCH_BYTES       = 8;                         // one doubleword per fetch
   localparam int PARCELS_PER_FETCH = FETCH_BYTES / 2;           // 16-bit parcels per fetch
   localparam int OFF_W             = $clog2(PARCELS_PER_FETCH); // parcel index width

   typedef logic [PC_W:1]                pc_t;          // halfword granular pc
   typedef logic [PC_W:OFF_W+1]          fetch_addr_t;  // doubleword fetch address
   typedef logic [FETCH_BYTES*8-1:0]     fetch_data_t;  // one memory return
   typedef logic [PARCELS_PER_FETCH-1:0] parcel_mask_t; // bit 0 is the lowest address
   typedef logic [OFF_W-1:0]             parcel_idx_t;  // parcel slot inside a fetch

   // parcels at or above off are kept
   function automatic parcel_mask_t parcel_mask_from(input parcel_idx_t off);
      parcel_mask_t m;
      m = {PARCELS_PER_FETCH{1'b1}};
      return m << off;
   endfunction

endpackage : ifu_geom_pkg

`default_nettype wire

//--- hdl/rv_parcel_pkg.sv
// instruction encoding package with parcel type, instruction union and length rule
`default_nettype none

package rv_parcel_pkg;

   localparam int PARCEL_W = 16;                 // rvc parcel size

   typedef logic [PARCEL_W-1:0] parcel_t;        // one instruction parcel

   // instr word split at the parcel boundary
   typedef struct packed {
      parcel_t hi;                               // upper parcel or zero for 2-byte instr
      parcel_t lo;                               // lower parcel at the instr pc
   } parcel_pair_t;

   // one word seen two ways
   typedef union packed {
      logic [2*PARCEL_W-1:0] word;               // full instr as decode sees it
      parcel_pair_t          half;               // as the aligner builds it
   } instr_u;

   // 2'b11 in the low bits opens a 4-byte instr
   function automatic logic parcel_is_long(input parcel_t p);
      return (p[1:0] == 2'b11);
   endfunction

endpackage : rv_parcel_pkg

`default_nettype wire

//--- hdl/ifu_fetch_ctl.sv
// F1 fetch control with fetch pc register, flush redirect and request issue
`default_nettype none

module ifu_fetch_ctl #(
   parameter ifu_geom_pkg::pc_t RESET_PC = ifu_geom_pkg::pc_t'(32'h0000_0100 >> 1) // byte 0x100
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              exu_flush_final,       // one cycle redirect pulse
   input  ifu_geom_pkg::pc_t exu_flush_path_final,  // redirect target
   input  logic              fb_room,               // buffer can take one more entry
   output logic              fetch_req_f1,          // request strobe to memory and F2
   output ifu_geom_pkg::pc_t fetch_pc_f1            // request pc with halfword offset
);

   import ifu_geom_pkg::*;

   pc_t  fetch_pc;                                  // next pc to fetch
   pc_t  fetch_pc_inc;                              // start of following doubleword
   logic fetch_run;                                 // set on first edge out of reset

   // **************************************************
   // request issue
   // **************************************************
   assign fetch_req_f1 = fetch_run & fb_room & ~exu_flush_final;   // hold off in flush cycle
   assign fetch_pc_f1  = fetch_pc;

   // offset bits clear after the first fetch of a run
   assign fetch_pc_inc = {fetch_pc[PC_W:OFF_W+1] + 1'b1, {OFF_W{1'b0}}};

   // **************************************************
   // fetch pc
   // **************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_run <= 1'b0;
         fetch_pc  <= RESET_PC;
      end else begin
         fetch_run <= 1'b1;
         if (exu_flush_final) begin
            fetch_pc <= exu_flush_path_final;       // redirected fetch may go next cycle
         end else if (fetch_req_f1) begin
            fetch_pc <= fetch_pc_inc;               // step to next doubleword
         end
      end
   end

   // a flush cycle never launches a fetch into F2
   a_no_req_flush: assert property (@(posedge clk) disable iff (!rst_n)
      exu_flush_final |-> !fetch_req_f1);

endmodule : ifu_fetch_ctl

`default_nettype wire

//--- hdl/ifu_fetch_buf.sv
// F2 capture register and fetch buffer queue with per-parcel valid masks
`default_nettype none

module ifu_fetch_buf #(
   parameter int FB_DEPTH = 4                        // queue entries
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       exu_flush_final,  // empties queue and F2
   input  logic                       fetch_req_f1,
   input  ifu_geom_pkg::pc_t          fetch_pc_f1,
   input  ifu_geom_pkg::fetch_data_t  imem_rdata,       // valid the cycle after the request
   input  logic                       fb_pop,           // aligner done with head entry
   output logic                       fb_room,
   output logic                       fb_valid,
   output ifu_geom_pkg::fetch_data_t  fb_data,
   output ifu_geom_pkg::parcel_mask_t fb_mask,
   output ifu_geom_pkg::pc_t          fb_pc             // doubleword pc of head entry
);

   import ifu_geom_pkg::*;

   localparam int PTR_W = (FB_DEPTH > 1) ? $clog2(FB_DEPTH) : 1;
   localparam int CNT_W = $clog2(FB_DEPTH + 1);

   logic             fetch_req_f2;                   // request in flight
   pc_t              fetch_pc_f2;                    // its pc with offset
   logic             fb_wr;
   logic             fb_rd;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] fb_cnt;                         // entries held
   logic [CNT_W:0]   fb_occ;                         // entries plus the one in flight

   fetch_data_t      data_q [FB_DEPTH];
   parcel_mask_t     mask_q [FB_DEPTH];
   pc_t              pc_q   [FB_DEPTH];

   // circular increment for any depth
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FB_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // **************************************************
   // F2 stage
   // **************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_req_f2 <= 1'b0;
      end else begin
         fetch_req_f2 <= fetch_req_f1;               // memory answers next cycle
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_req_f1) begin
         fetch_pc_f2 <= fetch_pc_f1;
      end
   end

   // **************************************************
   // queue
   // **************************************************
   assign fb_wr = fetch_req_f2 & ~exu_flush_final;   // flush drops the data in flight
   assign fb_rd = fb_pop & ~exu_flush_final;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fb_cnt <= '0;
      end else if (exu_flush_final) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fb_cnt <= '0;
      end else begin
         if (fb_wr) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (fb_rd) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         fb_cnt <= fb_cnt + CNT_W'(fb_wr) - CNT_W'(fb_rd);
      end
   end

   always_ff @(posedge clk) begin
      if (fb_wr) begin
         data_q[wr_ptr] <= imem_rdata;
         mask_q[wr_ptr] <= parcel_mask_from(fetch_pc_f2[OFF_W:1]);  // skip parcels below pc
         pc_q[wr_ptr]   <= {fetch_pc_f2[PC_W:OFF_W+1], {OFF_W{1'b0}}};
      end
   end

   // head entry
   assign fb_valid = (fb_cnt != '0);
   assign fb_data  = data_q[rd_ptr];
   assign fb_mask  = mask_q[rd_ptr];
   assign fb_pc    = pc_q[rd_ptr];

   // room counts the request still in flight
   assign fb_occ  = {1'b0, fb_cnt} + (CNT_W+1)'(fetch_req_f2);
   assign fb_room = (fb_occ < (CNT_W+1)'(FB_DEPTH));

   // room given in F1 still holds when the data lands
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      fb_wr |-> fb_cnt < CNT_W'(FB_DEPTH));

   // aligner only pops a live head
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
      fb_pop |-> fb_valid);

endmodule : ifu_fetch_buf

`default_nettype wire

//--- hdl/ifu_aligner.sv
// aligner cutting parcels into 2- and 4-byte instructions with decode output register
`default_nettype none

module ifu_aligner (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       exu_flush_final,   // drops output and carry
   input  logic                       fb_valid,
   input  ifu_geom_pkg::fetch_data_t  fb_data,
   input  ifu_geom_pkg::parcel_mask_t fb_mask,
   input  ifu_geom_pkg::pc_t          fb_pc,             // doubleword pc of head entry
   input  logic                       dec_take,          // decode takes output this cycle
   output logic                       fb_pop,            // head entry used up
   output logic                       ifu_i0_valid,
   output logic [31:0]                ifu_i0_instr,
   output ifu_geom_pkg::pc_t          ifu_i0_pc,
   output logic                       ifu_i0_pc4
);

   import ifu_geom_pkg::*;
   import rv_parcel_pkg::*;

   parcel_idx_t    par_idx;                     // next unused slot in head entry
   parcel_idx_t    cur_idx;                     // first valid slot at or above par_idx
   parcel_idx_t    nxt_idx;
   parcel_mask_t   avail;                       // valid slots not yet used
   parcel_t        cur_par;
   parcel_t        nxt_par;
   logic           cur_long;
   logic           pair_used;                   // two parcels from this entry
   logic           carry_vld;                   // low half of a 4-byte instr across entries
   parcel_t        carry_par;
   pc_t            carry_pc;
   logic [OFF_W:0] par_end;                     // slot after the parcels used now
   logic           out_load;                    // output empty or being taken
   logic           out_fire;
   logic           carry_fill;
   logic           consume;
   instr_u         ins;
   pc_t            ins_pc;

   // **************************************************
   // parcel selection
   // **************************************************
   assign avail = fb_mask & parcel_mask_from(par_idx);

   always_comb begin
      cur_idx = par_idx;
      for (int i = PARCELS_PER_FETCH - 1; i >= 0; i--) begin
         if (avail[i]) begin
            cur_idx = parcel_idx_t'(i);         // lowest wins
         end
      end
   end

   assign nxt_idx  = cur_idx + 1'b1;            // wraps on last slot where it is unused
   assign cur_par  = fb_data[cur_idx*PARCEL_W +: PARCEL_W];
   assign nxt_par  = fb_data[nxt_idx*PARCEL_W +: PARCEL_W];
   assign cur_long = parcel_is_long(cur_par);

   // **************************************************
   // instruction assembly
   // **************************************************
   always_comb begin
      ins = '0;
      if (carry_vld) begin
         ins.half.lo = carry_par;               // carried low half
         ins.half.hi = cur_par;
      end else begin
         ins.half.lo = cur_par;
         if (cur_long) begin
            ins.half.hi = nxt_par;              // 2-byte instr keeps hi at zero
         end
      end
   end

   assign ins_pc = carry_vld ? carry_pc : {fb_pc[PC_W:OFF_W+1], cur_idx};

   assign out_load   = ~ifu_i0_valid | dec_take;
   assign carry_fill = fb_valid & ~carry_vld & cur_long & (&cur_idx);  // long parcel in last slot
   assign out_fire   = fb_valid & out_load & ~carry_fill;
   assign consume    = out_fire | carry_fill;
   assign pair_used  = ~carry_vld & cur_long & ~(&cur_idx);
   assign par_end    = {1'b0, cur_idx} + (pair_used ? (OFF_W+1)'(2) : (OFF_W+1)'(1));
   assign fb_pop     = consume & par_end[OFF_W];   // ran past the last slot

   // **************************************************
   // control and output state
   // **************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         par_idx      <= '0;
         carry_vld    <= 1'b0;
         ifu_i0_valid <= 1'b0;
      end else if (exu_flush_final) begin
         par_idx      <= '0;
         carry_vld    <= 1'b0;
         ifu_i0_valid <= 1'b0;
      end else begin
         if (consume) begin
            par_idx <= par_end[OFF_W-1:0];      // back to 0 on pop
         end
         carry_vld <= carry_fill | (carry_vld & ~out_fire);
         if (out_load) begin
            ifu_i0_valid <= out_fire;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (carry_fill) begin
         carry_par <= cur_par;
         carry_pc  <= ins_pc;
      end
      if (out_fire) begin
         ifu_i0_instr <= ins.word;
         ifu_i0_pc    <= ins_pc;
         ifu_i0_pc4   <= parcel_is_long(ins.half.lo);
      end
   end

   // decode sees a steady instr until it takes it
   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_i0_valid && !dec_take && !exu_flush_final |=>
         ifu_i0_valid && $stable(ifu_i0_instr) && $stable(ifu_i0_pc) && $stable(ifu_i0_pc4));

endmodule : ifu_aligner

`default_nettype wire

//--- hdl/ifu.sv
// instruction fetch unit top with fetch control, fetch buffer and aligner
`default_nettype none

module ifu #(
   parameter ifu_geom_pkg::pc_t RESET_PC = ifu_geom_pkg::pc_t'(32'h0000_0100 >> 1), // byte 0x100
   parameter int                FB_DEPTH = 4                                        // buffer entries
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      exu_flush_final,       // one cycle redirect pulse
   input  ifu_geom_pkg::pc_t         exu_flush_path_final,  // valid with the flush pulse
   output logic                      imem_req,              // read strobe
   output ifu_geom_pkg::fetch_addr_t imem_addr,             // doubleword address
   input  ifu_geom_pkg::fetch_data_t imem_rdata,            // one cycle after imem_req
   input  logic                      dec_take,              // decode consumes i0
   output logic                      ifu_i0_valid,
   output logic [31:0]               ifu_i0_instr,
   output ifu_geom_pkg::pc_t         ifu_i0_pc,
   output logic                      ifu_i0_pc4
);

   import ifu_geom_pkg::*;

   logic         fetch_req_f1;
   pc_t          fetch_pc_f1;
   logic         fb_room;
   logic         fb_valid;
   fetch_data_t  fb_data;
   parcel_mask_t fb_mask;
   pc_t          fb_pc;
   logic         fb_pop;

   // memory sees the F1 request without the halfword offset
   assign imem_req  = fetch_req_f1;
   assign imem_addr = fetch_pc_f1[PC_W:OFF_W+1];

   ifu_fetch_ctl #(
      .RESET_PC             (RESET_PC)
   ) u_fetch_ctl (
      .clk                  (clk),
      .rst_n                (rst_n),
      .exu_flush_final      (exu_flush_final),
      .exu_flush_path_final (exu_flush_path_final),
      .fb_room              (fb_room),
      .fetch_req_f1         (fetch_req_f1),
      .fetch_pc_f1          (fetch_pc_f1)
   );

   ifu_fetch_buf #(
      .FB_DEPTH        (FB_DEPTH)
   ) u_fetch_buf (
      .clk             (clk),
      .rst_n           (rst_n),
      .exu_flush_final (exu_flush_final),
      .fetch_req_f1    (fetch_req_f1),
      .fetch_pc_f1     (fetch_pc_f1),
      .imem_rdata      (imem_rdata),
      .fb_pop          (fb_pop),
      .fb_room         (fb_room),
      .fb_valid        (fb_valid),
      .fb_data         (fb_data),
      .fb_mask         (fb_mask),
      .fb_pc           (fb_pc)
   );

   ifu_aligner u_aligner (
      .clk             (clk),
      .rst_n           (rst_n),
      .exu_flush_final (exu_flush_final),
      .fb_valid        (fb_valid),
      .fb_data         (fb_data),
      .fb_mask         (fb_mask),
      .fb_pc           (fb_pc),
      .dec_take        (dec_take),
      .fb_pop          (fb_pop),
      .ifu_i0_valid    (ifu_i0_valid),
      .ifu_i0_instr    (ifu_i0_instr),
      .ifu_i0_pc       (ifu_i0_pc),
      .ifu_i0_pc4      (ifu_i0_pc4)
   );

endmodule : ifu

`default_nettype wire

//--- tb/tb_ifu.sv
// ifu testbench with clock, reset, memory model, random stimulus, assertions, watchdog and report
`default_nettype none

module tb_ifu;

   import ifu_geom_pkg::*;

   localparam pc_t RESET_PC    = pc_t'(32'h0000_0100 >> 1);  // byte 0x100
   localparam int  FB_DEPTH    = 4;
   localparam int  MEM_AW      = 10;                        // parcel index is pc[10:1]
   localparam int  MEM_PARCELS = 1 << MEM_AW;               // 2 KB of code
   localparam int  RST_CYCLES  = 8;
   localparam int  N_CYCLES    = 3000;                      // random test cycles
   localparam int  WAIT_MAX    = 50;                        // first instr must show by then
   localparam int  STALL_HOLD  = 12;                        // fill the buffer at start
   localparam int  PERIOD      = 40;
   localparam int  WD_TIME     = (RST_CYCLES + WAIT_MAX + STALL_HOLD + N_CYCLES + 100) * PERIOD;

   logic        clk;
   logic        rst_n;
   logic        exu_flush_final;
   pc_t         exu_flush_path_final;
   logic        imem_req;
   fetch_addr_t imem_addr;
   fetch_data_t imem_rdata;
   logic        dec_take;
   logic        ifu_i0_valid;
   logic [31:0] ifu_i0_instr;
   pc_t         ifu_i0_pc;
   logic        ifu_i0_pc4;

   logic [15:0] mem_par [MEM_PARCELS];                      // code memory in parcels
   logic        rd_pend;                                    // read issued last edge
   fetch_addr_t rd_addr;
   pc_t         exp_pc;                                     // next pc decode should take
   fetch_addr_t exp_addr;                                   // next fetch address
   int          taken_cnt;
   int          flush_cnt;
   int          val_errs;                                   // wrong value errors
   int          ctl_errs;                                   // timing and protocol errors
   int          seed_dummy;
   int          wait_cyc;

   ifu #(
      .RESET_PC (RESET_PC),
      .FB_DEPTH (FB_DEPTH)
   ) u_ifu (
      .clk                  (clk),
      .rst_n                (rst_n),
      .exu_flush_final      (exu_flush_final),
      .exu_flush_path_final (exu_flush_path_final),
      .imem_req             (imem_req),
      .imem_addr            (imem_addr),
      .imem_rdata           (imem_rdata),
      .dec_take             (dec_take),
      .ifu_i0_valid         (ifu_i0_valid),
      .ifu_i0_instr         (ifu_i0_instr),
      .ifu_i0_pc            (ifu_i0_pc),
      .ifu_i0_pc4           (ifu_i0_pc4)
   );

   // low bits 11 start a 4-byte instr
   function automatic logic opens_long(input logic [15:0] p);
      return (p[1:0] == 2'b11);
   endfunction

   function automatic logic [15:0] par_at(input pc_t pc);
      return mem_par[pc[MEM_AW:1]];                         // wraps inside the memory
   endfunction

   function automatic fetch_data_t word_at(input fetch_addr_t a);
      fetch_data_t w;
      for (int i = 0; i < 4; i++) begin
         w[i*16 +: 16] = mem_par[{a[MEM_AW:3], 2'(i)}];     // parcel 0 at lowest address
      end
      return w;
   endfunction

   // **************************************************
   // clock, memory and scoreboard
   // **************************************************
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   always_ff @(posedge clk) begin
      rd_pend <= imem_req;
      rd_addr <= imem_addr;
   end

   always @(negedge clk) begin
      imem_rdata = rd_pend ? word_at(rd_addr) : '0;         // one cycle read latency
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exp_pc    <= RESET_PC;
         exp_addr  <= RESET_PC[PC_W:3];
         taken_cnt <= 0;
         flush_cnt <= 0;
      end else begin
         if (exu_flush_final) begin
            exp_pc    <= exu_flush_path_final;              // redirect both streams
            exp_addr  <= exu_flush_path_final[PC_W:3];
            flush_cnt <= flush_cnt + 1;
         end else begin
            if (ifu_i0_valid && dec_take) begin
               exp_pc    <= exp_pc + (opens_long(par_at(exp_pc)) ? pc_t'(2) : pc_t'(1));
               taken_cnt <= taken_cnt + 1;
            end
            if (imem_req) begin
               exp_addr <= exp_addr + 1'b1;
            end
         end
      end
   end

   // **************************************************
   // checks
   // **************************************************
   a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !imem_req && !ifu_i0_valid)
      else begin
         ctl_errs++;
         $display("imem_req or ifu_i0_valid high while reset is held at %0t", $time);
      end

   a_take_pc: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_i0_valid && dec_take && !exu_flush_final |-> ifu_i0_pc == exp_pc)
      else begin
         val_errs++;
         $display("[FAIL] %0t ifu_i0_pc expected %h got %h",
                  $time, $sampled(exp_pc), $sampled(ifu_i0_pc));
      end

   a_lo_parcel: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_i0_valid |-> ifu_i0_instr[15:0] == par_at(ifu_i0_pc))
      else begin
         val_errs++;
         $display("[FAIL] %0t ifu_i0_instr[15:0] expected %h got %h",
                  $time, par_at($sampled(ifu_i0_pc)), $sampled(ifu_i0_instr[15:0]));
      end

   a_pc4: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_i0_valid |-> ifu_i0_pc4 == opens_long(par_at(ifu_i0_pc)))
      else begin
         val_errs++;
         $display("[FAIL] %0t ifu_i0_pc4 expected %b got %b",
                  $time, opens_long(par_at($sampled(ifu_i0_pc))), $sampled(ifu_i0_pc4));
      end

   // hi half may come from the next doubleword
   a_hi_parcel: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_i0_valid |-> ifu_i0_instr[31:16] ==
         (opens_long(par_at(ifu_i0_pc)) ? par_at(ifu_i0_pc + 1'b1) : 16'h0000))
      else begin
         val_errs++;
         $display("[FAIL] %0t ifu_i0_instr[31:16] expected %h got %h", $time,
                  opens_long(par_at($sampled(ifu_i0_pc))) ?
                     par_at($sampled(ifu_i0_pc) + 1'b1) : 16'h0000,
                  $sampled(ifu_i0_instr[31:16]));
      end

   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_i0_valid && !dec_take && !exu_flush_final |=>
         ifu_i0_valid && $stable(ifu_i0_instr) && $stable(ifu_i0_pc) && $stable(ifu_i0_pc4))
      else begin
         ctl_errs++;
         $display("decode outputs changed while stalled at %0t", $time);
      end

   a_flush_drop: assert property (@(posedge clk) disable iff (!rst_n)
      exu_flush_final |=> !ifu_i0_valid)
      else begin
         ctl_errs++;
         $display("ifu_i0_valid still high the cycle after a flush at %0t", $time);
      end

   // covers reset address, flush redirect and the +1 walk
   a_fetch_addr: assert property (@(posedge clk) disable iff (!rst_n)
      imem_req |-> imem_addr == exp_addr)
      else begin
         val_errs++;
         $display("[FAIL] %0t imem_addr expected %h got %h",
                  $time, $sampled(exp_addr), $sampled(imem_addr));
      end

   // **************************************************
   // stimulus and report
   // **************************************************
   initial begin
      rst_n                = 1'b0;
      exu_flush_final      = 1'b0;
      exu_flush_path_final = '0;
      imem_rdata           = '0;
      dec_take             = 1'b0;
      val_errs             = 0;
      ctl_errs             = 0;
      seed_dummy           = $urandom(32'h7fce_35ce);
      for (int i = 0; i < MEM_PARCELS; i++) begin
         mem_par[i] = 16'($urandom);
      end

      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // first instr after reset, left waiting so the buffer fills
      wait_cyc = 0;
      while (!ifu_i0_valid && wait_cyc < WAIT_MAX) begin
         @(negedge clk);
         wait_cyc++;
      end
      if (!ifu_i0_valid) begin
         ctl_errs++;
         $display("no instruction presented within %0d cycles of reset", WAIT_MAX);
      end
      repeat (STALL_HOLD) @(negedge clk);

      repeat (N_CYCLES) begin
         @(negedge clk);
         dec_take = (($urandom % 10) < 7);                  // about 70% take
         if (($urandom % 32) == 0) begin
            exu_flush_final      = 1'b1;
            exu_flush_path_final = pc_t'($urandom % MEM_PARCELS);
         end else begin
            exu_flush_final      = 1'b0;
            exu_flush_path_final = '0;
         end
      end
      @(negedge clk);
      exu_flush_final = 1'b0;
      dec_take        = 1'b0;

      if (taken_cnt == 0 || flush_cnt == 0) begin
         ctl_errs++;
         $display("stimulus ran without taken instructions or without flushes");
      end
      $display("errors: value %0d, control %0d (taken %0d, flushes %0d)",
               val_errs, ctl_errs, taken_cnt, flush_cnt);
      if (val_errs == 0 && ctl_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin
      #(WD_TIME);
      $display("watchdog expired after %0d time units", WD_TIME);
      $display("Simulation FAILED");
      $finish;
   end

endmodule : tb_ifu

`default_nettype wire

//--- ifu_fetch.f
hdl/ifu_geom_pkg.sv
hdl/rv_parcel_pkg.sv
hdl/ifu_fetch_ctl.sv
hdl/ifu_fetch_buf.sv
hdl/ifu_aligner.sv
hdl/ifu.sv
tb/tb_ifu.sv

//--- run_sim.sh
#!/bin/sh
# Build the ifu testbench with Verilator, run it, and grade the run from its log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_ifu \
   -f ifu_fetch.f \
   -o vtb_ifu \
   && ./obj_dir/vtb_ifu > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }

cat sim.log

grep -q "Simulation PASSED" sim.log \
   && { echo "result: pass"; exit 0; } \
   || { echo "result: fail"; exit 1; }
